/* verilog/board_pkg.sv */
`default_nettype none

package board_pkg;

    // port widths
    localparam int joy_w     = 10;
    localparam int key_joy_w = 6;       // up, down, left, right, button 1, button 2
    localparam int gfx_w     = 4;
    localparam int code_w    = 8;

    // joystick bit positions, active low on the pads
    localparam int coin_bit  = 6;
    localparam int start_bit = 7;
    localparam int pause_bit = 8;

    // timing
    localparam int game_rst_cycles = 255;
    localparam int ps2_idle_cycles = 2000;   // gap that ends a broken frame
    localparam int ps2_idle_w      = $clog2(ps2_idle_cycles);
    localparam int ps2_frame_w     = 11;     // start, 8 data, parity, stop
    localparam int ps2_cnt_w       = $clog2(ps2_frame_w);

    // set 2 prefixes
    localparam logic [code_w-1:0] scan_break = 8'hf0;
    localparam logic [code_w-1:0] scan_ext   = 8'he0;

    // player 1
    localparam logic [code_w-1:0] sc_w = 8'h1d;
    localparam logic [code_w-1:0] sc_s = 8'h1b;
    localparam logic [code_w-1:0] sc_a = 8'h1c;
    localparam logic [code_w-1:0] sc_d = 8'h23;
    localparam logic [code_w-1:0] sc_f = 8'h2b;
    localparam logic [code_w-1:0] sc_g = 8'h34;
    // player 2
    localparam logic [code_w-1:0] sc_i = 8'h43;
    localparam logic [code_w-1:0] sc_k = 8'h42;
    localparam logic [code_w-1:0] sc_j = 8'h3b;
    localparam logic [code_w-1:0] sc_l = 8'h4b;
    localparam logic [code_w-1:0] sc_m = 8'h3a;
    localparam logic [code_w-1:0] sc_n = 8'h31;
    // start, coin and the rest
    localparam logic [code_w-1:0] sc_1   = 8'h16;
    localparam logic [code_w-1:0] sc_2   = 8'h1e;
    localparam logic [code_w-1:0] sc_5   = 8'h2e;
    localparam logic [code_w-1:0] sc_6   = 8'h36;
    localparam logic [code_w-1:0] sc_p   = 8'h4d;
    localparam logic [code_w-1:0] sc_esc = 8'h76;
    localparam logic [code_w-1:0] sc_f1  = 8'h05;
    localparam logic [code_w-1:0] sc_f2  = 8'h06;
    localparam logic [code_w-1:0] sc_f3  = 8'h04;
    localparam logic [code_w-1:0] sc_f4  = 8'h0c;

endpackage

`default_nettype wire

/* verilog/rst_hold_timer.sv */
`default_nettype none
`timescale 1ns/1ns

module rst_hold_timer #(
    parameter int hold_cycles = board_pkg::game_rst_cycles
) (
    input  wire  clk_rgb,
    input  wire  rst,
    input  wire  restart,
    output logic done
);
    import board_pkg::*;

    localparam int cnt_w = $clog2(hold_cycles);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(hold_cycles - 1);

    logic [cnt_w-1:0] cnt;

    // restart wins over the count, so a new trigger always starts from zero
    always_ff @(posedge clk_rgb) begin
        if (rst || restart) begin
            cnt <= '0;
        end else if (cnt != cnt_last) begin
            cnt <= cnt + 1'b1;
        end
    end

    // stays up until the next restart
    assign done = (cnt == cnt_last);

endmodule

`default_nettype wire

/* verilog/game_rst_fsm.sv */
`default_nettype none
`timescale 1ns/1ns

module game_rst_fsm (
    input  wire  clk_rgb,
    input  wire  rst,
    input  wire  dip_flip,
    input  wire  downloading,
    input  wire  rst_req,
    input  wire  soft_rst,
    input  wire  hold_done,
    output logic hold_restart,
    output logic game_rst
);
    import board_pkg::*;

    typedef enum logic {
        st_hold,
        st_run
    } state_t;

    state_t state;
    logic   flip_last;     // dip_flip one cycle back
    logic   trigger;

    // any of these holds the game, a flip of the screen switch included
    assign trigger = rst | downloading | rst_req | (dip_flip != flip_last) | soft_rst;

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            state     <= st_hold;
            flip_last <= dip_flip;
        end else begin
            flip_last <= dip_flip;
            case (state)
                st_run: begin
                    if (trigger) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    // a fresh trigger restarts the timer and keeps us here
                    if (!trigger && hold_done) begin
                        state <= st_run;
                    end
                end
                default: state <= st_hold;
            endcase
        end
    end

    assign hold_restart = trigger;   // timer clears on the same edge
    assign game_rst     = (state == st_hold);

endmodule

`default_nettype wire

/* verilog/ps2_rx.sv */
`default_nettype none
`timescale 1ns/1ns

module ps2_rx (
    input  wire                          clk_rgb,
    input  wire                          rst,
    input  wire                          ps2_clk,
    input  wire                          ps2_data,
    output logic [board_pkg::code_w-1:0] scan_code,
    output logic                         scan_valid
);
    import board_pkg::*;

    localparam logic [ps2_cnt_w-1:0]  cnt_last  = ps2_cnt_w'(ps2_frame_w - 1);
    localparam logic [ps2_idle_w-1:0] idle_last = ps2_idle_w'(ps2_idle_cycles - 1);

    logic [1:0]             clk_sync;
    logic [1:0]             data_sync;
    logic                   clk_last;
    logic                   fall;
    logic [ps2_frame_w-1:0] frame;
    logic [ps2_frame_w-1:0] frame_next;
    logic                   frame_ok;
    logic [ps2_cnt_w-1:0]   bit_cnt;
    logic [ps2_idle_w-1:0]  idle_cnt;

    assign fall       = clk_last & ~clk_sync[1];
    assign frame_next = {data_sync[1], frame[ps2_frame_w-1:1]};   // lsb first

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame_next[0] && frame_next[ps2_frame_w-1]
                      && (^frame_next[ps2_frame_w-2:1]);

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            clk_sync   <= '1;    // lines idle high
            data_sync  <= '1;
            clk_last   <= 1'b1;
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            scan_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            clk_last   <= clk_sync[1];
            scan_valid <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == cnt_last) begin
                    bit_cnt    <= '0;
                    scan_valid <= frame_ok;   // bad frames just vanish
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != '0) begin
                // keyboard went quiet mid frame
                if (idle_cnt == idle_last) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (fall) begin
            frame <= frame_next;
        end
        if (fall && bit_cnt == cnt_last) begin
            scan_code <= frame_next[code_w:1];
        end
    end

endmodule

`default_nettype wire

/* verilog/key_map.sv */
`default_nettype none
`timescale 1ns/1ns

module key_map (
    input  wire                             clk_rgb,
    input  wire                             rst,
    input  wire  [board_pkg::code_w-1:0]    scan_code,
    input  wire                             scan_valid,
    output logic [board_pkg::key_joy_w-1:0] key_joy1,
    output logic [board_pkg::key_joy_w-1:0] key_joy2,
    output logic [1:0]                      key_start,
    output logic [1:0]                      key_coin,
    output logic                            key_pause,
    output logic                            key_reset,
    output logic [board_pkg::gfx_w-1:0]     key_gfx
);
    import board_pkg::*;

    logic release_q;   // last prefix was f0
    logic ext_q;       // last prefix was e0
    logic make;

    assign make = ~release_q;

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            release_q <= 1'b0;
            ext_q     <= 1'b0;
            key_joy1  <= '0;
            key_joy2  <= '0;
            key_start <= '0;
            key_coin  <= '0;
            key_pause <= 1'b0;
            key_reset <= 1'b0;
            key_gfx   <= '0;
        end else if (scan_valid) begin
            if (scan_code == scan_break) begin
                release_q <= 1'b1;
            end else if (scan_code == scan_ext) begin
                ext_q <= 1'b1;
            end else begin
                release_q <= 1'b0;
                ext_q     <= 1'b0;
                // extended keys are not mapped, arrows included
                if (!ext_q) begin
                    case (scan_code)
                        sc_w:    key_joy1[0] <= make;   // up
                        sc_s:    key_joy1[1] <= make;   // down
                        sc_a:    key_joy1[2] <= make;   // left
                        sc_d:    key_joy1[3] <= make;   // right
                        sc_f:    key_joy1[4] <= make;
                        sc_g:    key_joy1[5] <= make;
                        sc_i:    key_joy2[0] <= make;
                        sc_k:    key_joy2[1] <= make;
                        sc_j:    key_joy2[2] <= make;
                        sc_l:    key_joy2[3] <= make;
                        sc_m:    key_joy2[4] <= make;
                        sc_n:    key_joy2[5] <= make;
                        sc_1:    key_start[0] <= make;
                        sc_2:    key_start[1] <= make;
                        sc_5:    key_coin[0] <= make;
                        sc_6:    key_coin[1] <= make;
                        sc_p:    key_pause <= make;
                        sc_esc:  key_reset <= make;
                        sc_f1:   key_gfx[0] <= make;
                        sc_f2:   key_gfx[1] <= make;
                        sc_f3:   key_gfx[2] <= make;
                        sc_f4:   key_gfx[3] <= make;
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/board_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

module board_ctrl (
    input  wire                             clk_rgb,
    input  wire                             rst,
    input  wire  [board_pkg::joy_w-1:0]     board_joystick1,
    input  wire  [board_pkg::joy_w-1:0]     board_joystick2,
    input  wire  [board_pkg::key_joy_w-1:0] key_joy1,
    input  wire  [board_pkg::key_joy_w-1:0] key_joy2,
    input  wire  [1:0]                      key_start,
    input  wire  [1:0]                      key_coin,
    input  wire                             key_pause,
    input  wire                             key_reset,
    input  wire  [board_pkg::gfx_w-1:0]     key_gfx,
    output logic [board_pkg::joy_w-1:0]     game_joystick1,
    output logic [board_pkg::joy_w-1:0]     game_joystick2,
    output logic [1:0]                      game_coin,
    output logic [1:0]                      game_start,
    output logic                            game_pause,
    output logic [board_pkg::gfx_w-1:0]     gfx_en,
    output logic                            soft_rst
);
    import board_pkg::*;

    logic [joy_w-1:0]     joy1_sync, joy2_sync;
    logic [key_joy_w-1:0] joy1_key_q, joy2_key_q;
    logic [1:0]           start_key_q, coin_key_q;
    logic                 pause_key_q, pause_key_last;
    logic                 reset_key_q, reset_key_last;
    logic [gfx_w-1:0]     gfx_key_q, gfx_key_last;
    logic                 joy_pause;
    logic                 joy_pause_last;

    // both pads active low, so the and falls when either presses pause
    assign joy_pause = joy1_sync[pause_bit] & joy2_sync[pause_bit];

    // pad path stays active low, a held key pulls its bit down
    always_ff @(posedge clk_rgb) begin
        joy1_sync      <= board_joystick1;
        joy2_sync      <= board_joystick2;
        game_joystick1 <= joy1_sync & ~{{(joy_w - key_joy_w){1'b0}}, joy1_key_q};
        game_joystick2 <= joy2_sync & ~{{(joy_w - key_joy_w){1'b0}}, joy2_key_q};
        game_coin      <= {joy2_sync[coin_bit], joy1_sync[coin_bit]} & ~coin_key_q;
        game_start     <= {joy2_sync[start_bit], joy1_sync[start_bit]} & ~start_key_q;
    end

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            joy1_key_q     <= '0;
            joy2_key_q     <= '0;
            start_key_q    <= '0;
            coin_key_q     <= '0;
            pause_key_q    <= 1'b0;
            pause_key_last <= 1'b0;
            reset_key_q    <= 1'b0;
            reset_key_last <= 1'b0;
            gfx_key_q      <= '0;
            gfx_key_last   <= '0;
            joy_pause_last <= 1'b1;
            game_pause     <= 1'b0;
            gfx_en         <= '1;     // all layers on
            soft_rst       <= 1'b0;
        end else begin
            joy1_key_q     <= key_joy1;
            joy2_key_q     <= key_joy2;
            start_key_q    <= key_start;
            coin_key_q     <= key_coin;
            pause_key_q    <= key_pause;
            pause_key_last <= pause_key_q;
            reset_key_q    <= key_reset;
            reset_key_last <= reset_key_q;
            gfx_key_q      <= key_gfx;
            gfx_key_last   <= gfx_key_q;
            joy_pause_last <= joy_pause;
            soft_rst       <= reset_key_q & ~reset_key_last;   // one pulse per press
            if ((pause_key_q && !pause_key_last) || (!joy_pause && joy_pause_last)) begin
                game_pause <= ~game_pause;
            end
            gfx_en <= gfx_en ^ (gfx_key_q & ~gfx_key_last);
        end
    end

endmodule

`default_nettype wire

/* verilog/board_top.sv */
`default_nettype none
`timescale 1ns/1ns

module board_top (
    input  wire                         clk_rgb,
    input  wire                         rst,
    input  wire                         dip_flip,
    input  wire                         downloading,
    input  wire                         rst_req,
    input  wire                         ps2_kbd_clk,
    input  wire                         ps2_kbd_data,
    input  wire  [board_pkg::joy_w-1:0] board_joystick1,
    input  wire  [board_pkg::joy_w-1:0] board_joystick2,
    output logic                        game_rst,
    output logic [board_pkg::joy_w-1:0] game_joystick1,
    output logic [board_pkg::joy_w-1:0] game_joystick2,
    output logic [1:0]                  game_coin,
    output logic [1:0]                  game_start,
    output logic                        game_pause,
    output logic [board_pkg::gfx_w-1:0] gfx_en
);

    wire [board_pkg::code_w-1:0]    scan_code;
    wire                            scan_valid;
    wire [board_pkg::key_joy_w-1:0] key_joy1, key_joy2;
    wire [1:0]                      key_start, key_coin;
    wire                            key_pause, key_reset;
    wire [board_pkg::gfx_w-1:0]     key_gfx;
    wire                            soft_rst;
    wire                            hold_restart, hold_done;

    ps2_rx u_ps2_rx (
        .clk_rgb    (clk_rgb),
        .rst        (rst),
        .ps2_clk    (ps2_kbd_clk),
        .ps2_data   (ps2_kbd_data),
        .scan_code  (scan_code),
        .scan_valid (scan_valid)
    );

    key_map u_key_map (
        .clk_rgb    (clk_rgb),
        .rst        (rst),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .key_joy1   (key_joy1),
        .key_joy2   (key_joy2),
        .key_start  (key_start),
        .key_coin   (key_coin),
        .key_pause  (key_pause),
        .key_reset  (key_reset),
        .key_gfx    (key_gfx)
    );

    board_ctrl u_board_ctrl (
        .clk_rgb         (clk_rgb),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_pause       (key_pause),
        .key_reset       (key_reset),
        .key_gfx         (key_gfx),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_pause      (game_pause),
        .gfx_en          (gfx_en),
        .soft_rst        (soft_rst)
    );

    game_rst_fsm u_game_rst_fsm (
        .clk_rgb      (clk_rgb),
        .rst          (rst),
        .dip_flip     (dip_flip),
        .downloading  (downloading),
        .rst_req      (rst_req),
        .soft_rst     (soft_rst),
        .hold_done    (hold_done),
        .hold_restart (hold_restart),
        .game_rst     (game_rst)
    );

    rst_hold_timer u_rst_hold_timer (
        .clk_rgb (clk_rgb),
        .rst     (rst),
        .restart (hold_restart),
        .done    (hold_done)
    );

endmodule

`default_nettype wire

/* dv/board_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module board_tb;
    import board_pkg::*;

    localparam int bit_cycles     = 40;   // clk_rgb cycles per ps2 bit
    localparam int settle_cycles  = 8;
    localparam int timeout_cycles = 40 * 11 * 80 + 10 * 300 + 4000;

    logic             clk_rgb = 1'b0;
    logic             rst;
    logic             dip_flip;
    logic             downloading;
    logic             rst_req;
    logic             ps2_kbd_clk;
    logic             ps2_kbd_data;
    logic [joy_w-1:0] board_joystick1;
    logic [joy_w-1:0] board_joystick2;
    logic             game_rst;
    logic [joy_w-1:0] game_joystick1;
    logic [joy_w-1:0] game_joystick2;
    logic [1:0]       game_coin;
    logic [1:0]       game_start;
    logic             game_pause;
    logic [gfx_w-1:0] gfx_en;

    int   cyc;
    int   rise_cyc;
    logic game_rst_last = 1'b0;
    int   checks;
    int   errors;
    int   seed;

    board_top dut_i (
        .clk_rgb         (clk_rgb),
        .rst             (rst),
        .dip_flip        (dip_flip),
        .downloading     (downloading),
        .rst_req         (rst_req),
        .ps2_kbd_clk     (ps2_kbd_clk),
        .ps2_kbd_data    (ps2_kbd_data),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .game_rst        (game_rst),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_pause      (game_pause),
        .gfx_en          (gfx_en)
    );

    initial begin
        forever #2 clk_rgb = ~clk_rgb;
    end

    // cycle count that also bounds the run
    always @(posedge clk_rgb) begin
        cyc <= cyc + 1;
        if (cyc == timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(negedge clk_rgb) begin
        if (game_rst && !game_rst_last) begin
            rise_cyc <= cyc;   // cycle where game_rst was first seen high
        end
        game_rst_last <= game_rst;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_rgb);
    endtask

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_kbd_data = frame[i];
            wait_cycles(bit_cycles / 2);
            ps2_kbd_clk = 1'b0;
            wait_cycles(bit_cycles / 2);
            ps2_kbd_clk = 1'b1;
        end
        ps2_kbd_data = 1'b1;
    endtask

    task automatic press_key(input logic [7:0] code);
        send_frame(code, 1'b0);
        wait_cycles(settle_cycles);
    endtask

    task automatic release_key(input logic [7:0] code);
        send_frame(scan_break, 1'b0);
        send_frame(code, 1'b0);
        wait_cycles(settle_cycles);
    endtask

    // call on the first negedge after the last trigger was sampled
    task automatic measure_hold(input string name);
        int k;
        k = 0;
        compare_value({name, " game_rst raised"}, 32'(game_rst), 32'd1);
        while (game_rst && k < 4 * game_rst_cycles) begin
            @(negedge clk_rgb);
            k++;
        end
        compare_value({name, " hold cycles"}, k, game_rst_cycles);
    endtask

    task automatic power_up_state();
        int err0;
        err0 = errors;
        compare_value("gfx_en", 32'(gfx_en), 32'((1 << gfx_w) - 1));
        compare_value("game_pause", 32'(game_pause), 32'd0);
        measure_hold("rst");
        report_test("after reset", err0);
    endtask

    task automatic game_reset_triggers();
        int err0;
        err0 = errors;
        rst_req = 1'b1;
        @(negedge clk_rgb);
        rst_req = 1'b0;
        measure_hold("rst_req");
        wait_cycles(5);
        compare_value("game_rst idle", 32'(game_rst), 32'd0);
        dip_flip = ~dip_flip;
        @(negedge clk_rgb);
        measure_hold("dip_flip");
        wait_cycles(5);
        downloading = 1'b1;
        wait_cycles(300);    // longer than the hold time
        compare_value("game_rst while downloading", 32'(game_rst), 32'd1);
        downloading = 1'b0;
        measure_hold("downloading");
        report_test("game reset triggers", err0);
    endtask

    task automatic joystick_path();
        int               err0;
        int               n;
        logic [31:0]      r;
        logic [joy_w-1:0] v1;
        logic [joy_w-1:0] v2;
        logic [joy_w-1:0] prev1;
        err0  = errors;
        prev1 = board_joystick1;
        for (n = 0; n < 20; n++) begin
            r  = $random(seed);
            v1 = r[joy_w-1:0];
            v2 = r[2*joy_w-1:joy_w];
            v1[pause_bit] = 1'b1;   // keep pause released here
            v2[pause_bit] = 1'b1;
            board_joystick1 = v1;
            board_joystick2 = v2;
            @(negedge clk_rgb);
            compare_value("game_joystick1 early", 32'(game_joystick1), 32'(prev1));
            @(negedge clk_rgb);
            compare_value("game_joystick1", 32'(game_joystick1), 32'(v1));
            compare_value("game_joystick2", 32'(game_joystick2), 32'(v2));
            compare_value("game_coin", 32'(game_coin), 32'({v2[coin_bit], v1[coin_bit]}));
            compare_value("game_start", 32'(game_start),
                          32'({v2[start_bit], v1[start_bit]}));
            prev1 = v1;
        end
        board_joystick1 = '1;
        board_joystick2 = '1;
        wait_cycles(3);
        compare_value("game_pause untouched", 32'(game_pause), 32'd0);
        report_test("joystick path", err0);
    endtask

    task automatic keyboard_path();
        int err0;
        err0 = errors;
        press_key(sc_w);
        compare_value("game_joystick1 W make", 32'(game_joystick1), 32'h3fe);  // up low
        release_key(sc_w);
        compare_value("game_joystick1 W break", 32'(game_joystick1), 32'h3ff);
        send_frame(sc_w, 1'b1);
        wait_cycles(settle_cycles);
        compare_value("game_joystick1 bad parity", 32'(game_joystick1), 32'h3ff);
        send_frame(scan_ext, 1'b0);
        press_key(sc_w);
        compare_value("game_joystick1 extended", 32'(game_joystick1), 32'h3ff);
        press_key(sc_1);
        compare_value("game_start key 1", 32'(game_start), 32'h2);
        press_key(sc_5);
        compare_value("game_coin key 5", 32'(game_coin), 32'h2);
        release_key(sc_1);
        release_key(sc_5);
        compare_value("game_start released", 32'(game_start), 32'h3);
        compare_value("game_coin released", 32'(game_coin), 32'h3);
        report_test("keyboard path", err0);
    endtask

    task automatic toggle_keys();
        int               err0;
        int               i;
        int               start_cyc;
        int               k;
        logic             pause_exp;
        logic [gfx_w-1:0] gfx_exp;
        logic [7:0]       gfx_codes [gfx_w];
        err0         = errors;
        gfx_codes[0] = sc_f1;
        gfx_codes[1] = sc_f2;
        gfx_codes[2] = sc_f3;
        gfx_codes[3] = sc_f4;
        pause_exp    = 1'b0;   // still off since reset
        press_key(sc_p);
        pause_exp = ~pause_exp;
        compare_value("game_pause P make", 32'(game_pause), 32'(pause_exp));
        press_key(sc_p);   // typematic repeat
        compare_value("game_pause P held", 32'(game_pause), 32'(pause_exp));
        release_key(sc_p);
        compare_value("game_pause P break", 32'(game_pause), 32'(pause_exp));
        board_joystick1[pause_bit] = 1'b0;
        wait_cycles(4);
        pause_exp = ~pause_exp;
        compare_value("game_pause pad press", 32'(game_pause), 32'(pause_exp));
        board_joystick1[pause_bit] = 1'b1;
        wait_cycles(4);
        compare_value("game_pause pad release", 32'(game_pause), 32'(pause_exp));
        gfx_exp = '1;   // all layers on since reset
        for (i = 0; i < gfx_w; i++) begin
            press_key(gfx_codes[i]);
            gfx_exp[i] = ~gfx_exp[i];
            compare_value("gfx_en make", 32'(gfx_en), 32'(gfx_exp));
            release_key(gfx_codes[i]);
            compare_value("gfx_en break", 32'(gfx_en), 32'(gfx_exp));
        end
        // esc goes through soft_rst into the game reset
        start_cyc = cyc;
        press_key(sc_esc);
        k = 0;
        while (game_rst && k < 4 * game_rst_cycles) begin
            @(negedge clk_rgb);
            k++;
        end
        compare_value("game_rst rose after esc", 32'(rise_cyc > start_cyc), 32'd1);
        compare_value("esc hold cycles", cyc - rise_cyc, game_rst_cycles);
        release_key(sc_esc);
        report_test("toggles", err0);
    endtask

    initial begin
        seed            = 32'h1960_b373;
        checks          = 0;
        errors          = 0;
        rst             = 1'b1;
        dip_flip        = 1'b0;
        downloading     = 1'b0;
        rst_req         = 1'b0;
        ps2_kbd_clk     = 1'b1;   // ps2 idles high
        ps2_kbd_data    = 1'b1;
        board_joystick1 = '1;
        board_joystick2 = '1;
        wait_cycles(10);
        rst = 1'b0;
        power_up_state();
        game_reset_triggers();
        joystick_path();
        keyboard_path();
        toggle_keys();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/board_pkg.sv
verilog/rst_hold_timer.sv
verilog/game_rst_fsm.sv
verilog/ps2_rx.sv
verilog/key_map.sv
verilog/board_ctrl.sv
verilog/board_top.sv
dv/board_tb.sv

/* run_sim.sh */
#!/bin/sh
# build board_tb with Verilator and run it; exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module board_tb \
    -f vlog.f -o board_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/board_sim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1
